// ==== echo_settings.svh ====
// UDP echo service settings
// Echo port, local address, reply TTL and queue depths shared by the
// port filter, the top level and the testbench

`ifndef ECHO_SETTINGS_SVH
`define ECHO_SETTINGS_SVH

// Destination port that gets answered
`define ECHO_UDP_PORT 16'd1234

// Source address of replies, 192.168.1.128
`define ECHO_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// TTL placed in every reply
`define ECHO_REPLY_TTL 8'd64

// Reply header queue entries
`define ECHO_HDR_FIFO_DEPTH 4

// Payload queue entries, in 64-bit beats
`define ECHO_PAYLOAD_FIFO_DEPTH 64

`endif

// ==== udp_hdr_pkg.sv ====
// UDP/IP header types
// Field types of the UDP and IP headers seen by the echo service and
// the reply header that is queued between filter and sender

package udp_hdr_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload bytes
    typedef logic [15:0] udp_len_t;

    // IP time to live
    typedef logic [7:0] ip_ttl_t;

    // UDP checksum, zero when not computed
    typedef logic [15:0] udp_csum_t;

    // Reply header as it sits in the header queue
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
        ip_ttl_t   ttl;
        udp_csum_t checksum;
    } reply_hdr_t;

endpackage

// ==== stream_pkg.sv ====
// Payload stream types
// Widths and beat layout of the 64-bit payload stream with byte keep,
// last and user flags

package stream_pkg;

    localparam int PAYLOAD_WIDTH = 64;
    localparam int KEEP_WIDTH    = PAYLOAD_WIDTH / 8;

    // One beat of payload as held in the payload queue
    typedef struct packed {
        logic [PAYLOAD_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0]    keep;
        logic                     last;
        logic                     user;
    } payload_beat_t;

endpackage

// ==== udp_fifo.sv ====
// Synchronous valid/ready FIFO
// Circular buffer with read and write pointers and an item count.
// Accepts while not full and presents the oldest item while not empty.
// The stored item type and the depth are parameters.

`timescale 1ns/1ps

module udp_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst,

    input  item_t in_item,
    input  logic  in_valid,
    output logic  in_ready,

    output item_t out_item,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_item  = mem[rd_ptr];

    assign do_wr = in_valid && in_ready;
    assign do_rd = out_valid && out_ready;

    // Storage array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count as is
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== udp_port_filter.sv ====
// UDP port filter
// Accepts one header per frame and decides echo or drop on the
// destination port. Echoed frames get a reply header pushed into the
// header queue and their payload steered into the payload queue.
// Dropped frames have their payload swallowed.

`timescale 1ns/1ps

`include "echo_settings.svh"

module udp_port_filter import udp_hdr_pkg::*, stream_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  ip_addr_t                 rx_src_ip,
    input  udp_port_t                rx_src_port,
    input  udp_port_t                rx_dst_port,
    input  udp_len_t                 rx_length,

    input  logic [PAYLOAD_WIDTH-1:0] rx_payload_data,
    input  logic [KEEP_WIDTH-1:0]    rx_payload_keep,
    input  logic                     rx_payload_valid,
    output logic                     rx_payload_ready,
    input  logic                     rx_payload_last,
    input  logic                     rx_payload_user,

    output reply_hdr_t               reply_hdr,
    output logic                     reply_hdr_valid,
    input  logic                     reply_hdr_ready,

    output payload_beat_t            echo_beat,
    output logic                     echo_beat_valid,
    input  logic                     echo_beat_ready
);

    logic run;
    logic frame_open;
    logic echo_frame;
    logic port_match;
    logic hdr_xfer;
    logic beat_xfer;

    assign port_match = (rx_dst_port == `ECHO_UDP_PORT);

    // No new header while a frame is open; echoed ones need header queue room
    assign rx_hdr_ready    = run && !frame_open && (!port_match || reply_hdr_ready);
    assign reply_hdr_valid = rx_hdr_valid && run && !frame_open && port_match;
    assign hdr_xfer        = rx_hdr_valid && rx_hdr_ready;

    // Reply goes back to the sender from the local address
    assign reply_hdr = '{
        src_ip:   `ECHO_LOCAL_IP,
        dst_ip:   rx_src_ip,
        src_port: rx_dst_port,
        dst_port: rx_src_port,
        length:   rx_length,
        ttl:      `ECHO_REPLY_TTL,
        checksum: '0
    };

    // Payload steering
    assign echo_beat = '{
        data: rx_payload_data,
        keep: rx_payload_keep,
        last: rx_payload_last,
        user: rx_payload_user
    };
    assign echo_beat_valid  = frame_open && echo_frame && rx_payload_valid;
    assign rx_payload_ready = frame_open && (echo_frame ? echo_beat_ready : 1'b1);
    assign beat_xfer        = rx_payload_valid && rx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            run        <= 1'b0;
            frame_open <= 1'b0;
            echo_frame <= 1'b0;
        end else begin
            run <= 1'b1;
            if (hdr_xfer) begin
                frame_open <= 1'b1;
                echo_frame <= port_match;
            end else if (beat_xfer && rx_payload_last) begin
                frame_open <= 1'b0;
            end
        end
    end

endmodule

// ==== udp_reply_tx.sv ====
// Reply sender
// Two-phase sequencer that sends each queued reply header and then the
// beats of its payload up to the last one. The low nibble of the first
// payload byte of every reply is held on the user LEDs.

`timescale 1ns/1ps

module udp_reply_tx import udp_hdr_pkg::*, stream_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    input  reply_hdr_t               hdr_in,
    input  logic                     hdr_in_valid,
    output logic                     hdr_in_ready,

    input  payload_beat_t            beat_in,
    input  logic                     beat_in_valid,
    output logic                     beat_in_ready,

    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output ip_addr_t                 tx_src_ip,
    output ip_addr_t                 tx_dst_ip,
    output udp_port_t                tx_src_port,
    output udp_port_t                tx_dst_port,
    output udp_len_t                 tx_length,
    output ip_ttl_t                  tx_ttl,
    output udp_csum_t                tx_checksum,

    output logic [PAYLOAD_WIDTH-1:0] tx_payload_data,
    output logic [KEEP_WIDTH-1:0]    tx_payload_keep,
    output logic                     tx_payload_valid,
    input  logic                     tx_payload_ready,
    output logic                     tx_payload_last,
    output logic                     tx_payload_user,

    output logic [3:0]               user_led
);

    typedef enum logic {
        ST_HDR,
        ST_PAYLOAD
    } state_t;

    state_t state;
    logic   first_beat;
    logic   hdr_xfer;
    logic   beat_xfer;

    // Header phase
    assign tx_hdr_valid = (state == ST_HDR) && hdr_in_valid;
    assign hdr_in_ready = (state == ST_HDR) && tx_hdr_ready;
    assign hdr_xfer     = tx_hdr_valid && tx_hdr_ready;

    assign tx_src_ip   = hdr_in.src_ip;
    assign tx_dst_ip   = hdr_in.dst_ip;
    assign tx_src_port = hdr_in.src_port;
    assign tx_dst_port = hdr_in.dst_port;
    assign tx_length   = hdr_in.length;
    assign tx_ttl      = hdr_in.ttl;
    assign tx_checksum = hdr_in.checksum;

    // Payload phase
    assign tx_payload_valid = (state == ST_PAYLOAD) && beat_in_valid;
    assign beat_in_ready    = (state == ST_PAYLOAD) && tx_payload_ready;
    assign beat_xfer        = tx_payload_valid && tx_payload_ready;

    assign tx_payload_data = beat_in.data;
    assign tx_payload_keep = beat_in.keep;
    assign tx_payload_last = beat_in.last;
    assign tx_payload_user = beat_in.user;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_HDR;
            first_beat <= 1'b0;
            user_led   <= 4'h0;
        end else begin
            case (state)
                ST_HDR: begin
                    if (hdr_xfer) begin
                        state      <= ST_PAYLOAD;
                        first_beat <= 1'b1;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_xfer) begin
                        first_beat <= 1'b0;
                        if (first_beat) begin
                            user_led <= beat_in.data[3:0];
                        end
                        if (beat_in.last) begin
                            state <= ST_HDR;
                        end
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

endmodule

// ==== udp_echo_top.sv ====
// UDP echo top level
// Port filter feeding a reply header queue and a payload queue, both
// drained by the reply sender

`timescale 1ns/1ps

`include "echo_settings.svh"

module udp_echo_top import udp_hdr_pkg::*, stream_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  ip_addr_t                 rx_src_ip,
    input  udp_port_t                rx_src_port,
    input  udp_port_t                rx_dst_port,
    input  udp_len_t                 rx_length,

    input  logic [PAYLOAD_WIDTH-1:0] rx_payload_data,
    input  logic [KEEP_WIDTH-1:0]    rx_payload_keep,
    input  logic                     rx_payload_valid,
    output logic                     rx_payload_ready,
    input  logic                     rx_payload_last,
    input  logic                     rx_payload_user,

    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output ip_addr_t                 tx_src_ip,
    output ip_addr_t                 tx_dst_ip,
    output udp_port_t                tx_src_port,
    output udp_port_t                tx_dst_port,
    output udp_len_t                 tx_length,
    output ip_ttl_t                  tx_ttl,
    output udp_csum_t                tx_checksum,

    output logic [PAYLOAD_WIDTH-1:0] tx_payload_data,
    output logic [KEEP_WIDTH-1:0]    tx_payload_keep,
    output logic                     tx_payload_valid,
    input  logic                     tx_payload_ready,
    output logic                     tx_payload_last,
    output logic                     tx_payload_user,

    output logic [3:0]               user_led
);

    // Filter to queues
    reply_hdr_t    reply_hdr;
    logic          reply_hdr_valid;
    logic          reply_hdr_ready;
    payload_beat_t echo_beat;
    logic          echo_beat_valid;
    logic          echo_beat_ready;

    // Queues to sender
    reply_hdr_t    hdr_q;
    logic          hdr_q_valid;
    logic          hdr_q_ready;
    payload_beat_t beat_q;
    logic          beat_q_valid;
    logic          beat_q_ready;

    udp_port_filter u_port_filter (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_src_ip        (rx_src_ip),
        .rx_src_port      (rx_src_port),
        .rx_dst_port      (rx_dst_port),
        .rx_length        (rx_length),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_keep  (rx_payload_keep),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_user  (rx_payload_user),
        .reply_hdr        (reply_hdr),
        .reply_hdr_valid  (reply_hdr_valid),
        .reply_hdr_ready  (reply_hdr_ready),
        .echo_beat        (echo_beat),
        .echo_beat_valid  (echo_beat_valid),
        .echo_beat_ready  (echo_beat_ready)
    );

    udp_fifo #(
        .item_t (reply_hdr_t),
        .DEPTH  (`ECHO_HDR_FIFO_DEPTH)
    ) u_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_item   (reply_hdr),
        .in_valid  (reply_hdr_valid),
        .in_ready  (reply_hdr_ready),
        .out_item  (hdr_q),
        .out_valid (hdr_q_valid),
        .out_ready (hdr_q_ready)
    );

    udp_fifo #(
        .item_t (payload_beat_t),
        .DEPTH  (`ECHO_PAYLOAD_FIFO_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_item   (echo_beat),
        .in_valid  (echo_beat_valid),
        .in_ready  (echo_beat_ready),
        .out_item  (beat_q),
        .out_valid (beat_q_valid),
        .out_ready (beat_q_ready)
    );

    udp_reply_tx u_reply_tx (
        .clk              (clk),
        .rst              (rst),
        .hdr_in           (hdr_q),
        .hdr_in_valid     (hdr_q_valid),
        .hdr_in_ready     (hdr_q_ready),
        .beat_in          (beat_q),
        .beat_in_valid    (beat_q_valid),
        .beat_in_ready    (beat_q_ready),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_src_ip        (tx_src_ip),
        .tx_dst_ip        (tx_dst_ip),
        .tx_src_port      (tx_src_port),
        .tx_dst_port      (tx_dst_port),
        .tx_length        (tx_length),
        .tx_ttl           (tx_ttl),
        .tx_checksum      (tx_checksum),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_keep  (tx_payload_keep),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload_last  (tx_payload_last),
        .tx_payload_user  (tx_payload_user),
        .user_led         (user_led)
    );

endmodule

// ==== udp_echo_props.sv ====
// UDP echo output properties
// Concurrent checks on the reply header and payload streams and on the
// user LEDs, bound to the echo top level

`timescale 1ns/1ps

module udp_echo_props import stream_pkg::*; (
    input logic                     clk,
    input logic                     rst,
    input logic                     tx_hdr_valid,
    input logic                     tx_hdr_ready,
    input logic [31:0]              tx_src_ip,
    input logic [31:0]              tx_dst_ip,
    input logic [15:0]              tx_src_port,
    input logic [15:0]              tx_dst_port,
    input logic [15:0]              tx_length,
    input logic [7:0]               tx_ttl,
    input logic [15:0]              tx_checksum,
    input logic [PAYLOAD_WIDTH-1:0] tx_payload_data,
    input logic [KEEP_WIDTH-1:0]    tx_payload_keep,
    input logic                     tx_payload_valid,
    input logic                     tx_payload_ready,
    input logic                     tx_payload_last,
    input logic                     tx_payload_user,
    input logic [3:0]               user_led
);

    logic in_payload;
    logic first_beat;
    logic hdr_xfer;
    logic beat_xfer;

    assign hdr_xfer  = tx_hdr_valid && tx_hdr_ready;
    assign beat_xfer = tx_payload_valid && tx_payload_ready;

    // Phase tracked from the output handshakes alone
    always_ff @(posedge clk) begin
        if (rst) begin
            in_payload <= 1'b0;
            first_beat <= 1'b0;
        end else if (hdr_xfer) begin
            in_payload <= 1'b1;
            first_beat <= 1'b1;
        end else if (beat_xfer) begin
            first_beat <= 1'b0;
            if (tx_payload_last) begin
                in_payload <= 1'b0;
            end
        end
    end

    a_hdr_stable: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable({tx_src_ip, tx_dst_ip,
            tx_src_port, tx_dst_port, tx_length, tx_ttl, tx_checksum}))
        else $error("reply header dropped or changed while stalled");

    a_beat_stable: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable({tx_payload_data,
            tx_payload_keep, tx_payload_last, tx_payload_user}))
        else $error("payload beat dropped or changed while stalled");

    a_beat_phase: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid |-> in_payload)
        else $error("payload beat valid outside the payload phase");

    a_led_update: assert property (@(posedge clk) disable iff (rst)
        !$stable(user_led) |-> $past(first_beat && beat_xfer))
        else $error("user_led changed without a first beat transfer");

endmodule

bind udp_echo_top udp_echo_props u_props (
    .clk              (clk),
    .rst              (rst),
    .tx_hdr_valid     (tx_hdr_valid),
    .tx_hdr_ready     (tx_hdr_ready),
    .tx_src_ip        (tx_src_ip),
    .tx_dst_ip        (tx_dst_ip),
    .tx_src_port      (tx_src_port),
    .tx_dst_port      (tx_dst_port),
    .tx_length        (tx_length),
    .tx_ttl           (tx_ttl),
    .tx_checksum      (tx_checksum),
    .tx_payload_data  (tx_payload_data),
    .tx_payload_keep  (tx_payload_keep),
    .tx_payload_valid (tx_payload_valid),
    .tx_payload_ready (tx_payload_ready),
    .tx_payload_last  (tx_payload_last),
    .tx_payload_user  (tx_payload_user),
    .user_led         (user_led)
);

// ==== tb_udp_echo.sv ====
// UDP echo testbench
// Sends the frames of the vectors file, stalls the reply streams at
// random and compares every reply header, payload beat and LED value
// with values derived from the sent frames

`timescale 1ns/1ps

`include "echo_settings.svh"

module tb_udp_echo;

    localparam int WAIT_LIMIT = 4000;

    typedef struct {
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } exp_hdr_t;

    typedef struct {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } exp_beat_t;

    logic        clk;
    logic        rst;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    logic [31:0] rx_src_ip;
    logic [15:0] rx_src_port;
    logic [15:0] rx_dst_port;
    logic [15:0] rx_length;
    logic [63:0] rx_payload_data;
    logic [7:0]  rx_payload_keep;
    logic        rx_payload_valid;
    logic        rx_payload_ready;
    logic        rx_payload_last;
    logic        rx_payload_user;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    logic [31:0] tx_src_ip;
    logic [31:0] tx_dst_ip;
    logic [15:0] tx_src_port;
    logic [15:0] tx_dst_port;
    logic [15:0] tx_length;
    logic [7:0]  tx_ttl;
    logic [15:0] tx_checksum;
    logic [63:0] tx_payload_data;
    logic [7:0]  tx_payload_keep;
    logic        tx_payload_valid;
    logic        tx_payload_ready;
    logic        tx_payload_last;
    logic        tx_payload_user;
    logic [3:0]  user_led;

    exp_hdr_t    exp_hdr_q[$];
    exp_beat_t   exp_beat_q[$];
    logic [31:0] data_lfsr;
    logic [31:0] stall_lfsr;
    int          errors;
    int          timeouts;
    int          echo_expected;
    int          hdr_seen;
    int          beats_seen;
    int          frames_done;
    logic        mon_first;
    logic        led_pending;
    logic [3:0]  led_exp;

    udp_echo_top u_udp_echo_top (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_src_ip        (rx_src_ip),
        .rx_src_port      (rx_src_port),
        .rx_dst_port      (rx_dst_port),
        .rx_length        (rx_length),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_keep  (rx_payload_keep),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_user  (rx_payload_user),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_src_ip        (tx_src_ip),
        .tx_dst_ip        (tx_dst_ip),
        .tx_src_port      (tx_src_port),
        .tx_dst_port      (tx_dst_port),
        .tx_length        (tx_length),
        .tx_ttl           (tx_ttl),
        .tx_checksum      (tx_checksum),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_keep  (tx_payload_keep),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload_last  (tx_payload_last),
        .tx_payload_user  (tx_payload_user),
        .user_led         (user_led)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, inout logic [31:0] st, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v  = {v[62:0], st[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Called mid low phase after the readies for this cycle are driven
    task automatic wait_accept(input logic for_hdr, input string what);
        int   cnt;
        logic done;
        cnt  = 0;
        done = 1'b0;
        while (!done && timeouts == 0) begin
            #2;
            if (for_hdr ? rx_hdr_ready : rx_payload_ready) begin
                done = 1'b1;
            end else begin
                cnt++;
                if (cnt > WAIT_LIMIT) begin
                    timeouts++;
                    $display("Timeout at %0t ns: %s never accepted by the DUT", $time, what);
                end else begin
                    @(negedge clk);
                end
            end
        end
        if (done) begin
            @(negedge clk);
        end
    endtask

    task automatic send_frame(input logic [31:0] ip, input logic [15:0] sp,
                              input logic [15:0] dp, input logic [15:0] len,
                              input int beats, input logic [7:0] keep, input logic echo);
        exp_hdr_t    h;
        exp_beat_t   eb;
        logic [63:0] bits;
        logic [63:0] ubit;
        rx_src_ip    = ip;
        rx_src_port  = sp;
        rx_dst_port  = dp;
        rx_length    = len;
        rx_hdr_valid = 1'b1;
        if (echo) begin
            // Ports swap and the sender becomes the destination
            h.dst_ip   = ip;
            h.src_port = dp;
            h.dst_port = sp;
            h.length   = len;
            exp_hdr_q.push_back(h);
        end
        wait_accept(1'b1, "header");
        rx_hdr_valid = 1'b0;
        if (timeouts != 0) begin
            return;
        end
        for (int b = 0; b < beats; b++) begin
            take_bits(64, data_lfsr, bits);
            take_bits(1, data_lfsr, ubit);
            rx_payload_data  = bits;
            rx_payload_keep  = (b == beats - 1) ? keep : 8'hff;
            rx_payload_last  = (b == beats - 1);
            rx_payload_user  = ubit[0];
            rx_payload_valid = 1'b1;
            if (echo) begin
                eb.data = rx_payload_data;
                eb.keep = rx_payload_keep;
                eb.last = rx_payload_last;
                eb.user = rx_payload_user;
                exp_beat_q.push_back(eb);
            end
            wait_accept(1'b0, "payload beat");
            if (timeouts != 0) begin
                rx_payload_valid = 1'b0;
                return;
            end
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic check_outputs();
        exp_hdr_t  h;
        exp_beat_t eb;
        if (led_pending) begin
            check_val("user_led", 64'(user_led), 64'(led_exp));
            led_pending = 1'b0;
        end
        if (tx_hdr_valid && tx_hdr_ready) begin
            hdr_seen++;
            if (exp_hdr_q.size() == 0) begin
                errors++;
                $display("Reply header at %0t ns with no echoed frame pending", $time);
            end else begin
                h = exp_hdr_q.pop_front();
                check_val("tx_src_ip", 64'(tx_src_ip), 64'(`ECHO_LOCAL_IP));
                check_val("tx_dst_ip", 64'(tx_dst_ip), 64'(h.dst_ip));
                check_val("tx_src_port", 64'(tx_src_port), 64'(h.src_port));
                check_val("tx_dst_port", 64'(tx_dst_port), 64'(h.dst_port));
                check_val("tx_length", 64'(tx_length), 64'(h.length));
                check_val("tx_ttl", 64'(tx_ttl), 64'(`ECHO_REPLY_TTL));
                check_val("tx_checksum", 64'(tx_checksum), 64'(0));
            end
            mon_first = 1'b1;
        end
        if (tx_payload_valid && tx_payload_ready) begin
            beats_seen++;
            if (exp_beat_q.size() == 0) begin
                errors++;
                $display("Payload beat at %0t ns with no echoed beat pending", $time);
            end else begin
                eb = exp_beat_q.pop_front();
                check_val("tx_payload_data", tx_payload_data, eb.data);
                check_val("tx_payload_keep", 64'(tx_payload_keep), 64'(eb.keep));
                check_val("tx_payload_last", 64'(tx_payload_last), 64'(eb.last));
                check_val("tx_payload_user", 64'(tx_payload_user), 64'(eb.user));
                if (mon_first) begin
                    led_exp = eb.data[3:0];
                end
                if (eb.last) begin
                    led_pending = 1'b1;
                    frames_done++;
                end
            end
            mon_first = 1'b0;
        end
    endtask

    // Output side with random stalls on both tx readies
    initial begin
        logic [63:0] sb;
        logic        active;
        forever begin
            // Reset only changes on falling edges
            @(posedge clk);
            active = !rst;
            @(negedge clk);
            if (!active) begin
                tx_hdr_ready     = 1'b0;
                tx_payload_ready = 1'b0;
            end else begin
                take_bits(2, stall_lfsr, sb);
                tx_hdr_ready = |sb[1:0];
                take_bits(2, stall_lfsr, sb);
                tx_payload_ready = |sb[1:0];
                #2;
                check_outputs();
            end
        end
    end

    initial begin
        int          fd;
        int          n;
        int          cnt;
        string       line;
        logic [31:0] v_ip;
        logic [15:0] v_sp;
        logic [15:0] v_dp;
        logic [15:0] v_len;
        logic [7:0]  v_keep;
        int          v_beats;
        int          v_echo;
        rst              = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_src_ip        = '0;
        rx_src_port      = '0;
        rx_dst_port      = '0;
        rx_length        = '0;
        rx_payload_data  = '0;
        rx_payload_keep  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        data_lfsr        = 32'hc7c5;
        stall_lfsr       = 32'hc7c5;
        errors           = 0;
        timeouts         = 0;
        echo_expected    = 0;
        hdr_seen         = 0;
        beats_seen       = 0;
        frames_done      = 0;
        mon_first        = 1'b0;
        led_pending      = 1'b0;
        led_exp          = 4'h0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_val("rx_hdr_ready", 64'(rx_hdr_ready), 64'(0));
        rst = 1'b0;
        #2;
        check_val("tx_hdr_valid", 64'(tx_hdr_valid), 64'(0));
        check_val("tx_payload_valid", 64'(tx_payload_valid), 64'(0));
        check_val("user_led", 64'(user_led), 64'(0));
        @(negedge clk);
        check_val("rx_hdr_ready", 64'(rx_hdr_ready), 64'(1));

        fd = $fopen("udp_echo_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the vectors file udp_echo_vectors.txt");
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %d %h %d",
                                v_ip, v_sp, v_dp, v_len, v_beats, v_keep, v_echo);
                    if (n != 7) begin
                        errors++;
                        $display("Malformed vectors line: %s", line);
                    end else begin
                        if (v_echo != 0) begin
                            echo_expected++;
                        end
                        send_frame(v_ip, v_sp, v_dp, v_len, v_beats, v_keep, v_echo != 0);
                    end
                end
            end
            $fclose(fd);
        end

        // Let the queued replies drain
        cnt = 0;
        while ((exp_hdr_q.size() != 0 || exp_beat_q.size() != 0 || led_pending)
               && timeouts == 0) begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                timeouts++;
                $display("Timeout at %0t ns: replies still outstanding", $time);
            end
        end
        repeat (16) @(negedge clk);
        #2;
        check_val("tx_hdr_valid", 64'(tx_hdr_valid), 64'(0));
        check_val("tx_payload_valid", 64'(tx_payload_valid), 64'(0));
        if (frames_done != echo_expected) begin
            errors++;
            $display("Echoed %0d frames but %0d were expected", frames_done, echo_expected);
        end

        $display("Done: %0d errors, %0d timeouts, %0d headers, %0d beats, %0d frames",
                 errors, timeouts, hdr_seen, beats_seen, frames_done);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== udp_echo_vectors.txt ====
# One frame per line, hex unless noted
# src_ip src_port dst_port length beats(dec) last_keep echo(dec)
c0a80105 c350 04d2 0018 2 ff 1
c0a80106 1f90 0050 0014 2 0f 0
0a000001 0400 04d2 000c 1 0f 1
0a000002 0401 04d2 0009 1 01 1
ac100010 ea60 04d3 0028 4 ff 0
c0a80107 8000 04d2 0050 9 ff 1
c0a80108 8001 0035 000b 1 07 0
c0a80109 9000 04d2 00a3 20 07 1
c0a8010a 9001 04d2 0011 2 01 1
0a0a0a0a abcd 04d2 0016 2 3f 1
0a0a0a0b abce 0000 000f 1 7f 0
7f000001 0001 04d2 0010 1 ff 1
c0a8010b ffff 04d2 0148 40 ff 1
c0a8010c 1234 04d2 000a 1 03 1
c0a8010d 4321 ffff 0010 1 ff 0
c0a8010e 5555 04d2 002f 5 7f 1
c0a8010f 0777 04d2 0011 2 01 1
0a000003 2222 04d2 00c8 24 ff 1

// ==== tb.f ====
+incdir+.
udp_hdr_pkg.sv
stream_pkg.sv
udp_fifo.sv
udp_port_filter.sv
udp_reply_tx.sv
udp_echo_top.sv
udp_echo_props.sv
tb_udp_echo.sv

// ==== Makefile ====
# Verilator build and run of the UDP echo testbench

VERILATOR ?= verilator
TOP       ?= tb_udp_echo
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
